// ==== src/tracerPkg.sv ====
`default_nettype none

package tracerPkg;

  // Signed Q12.12 fixed point is used for every vector and distance
  localparam int FRAC_BITS = 12;
  localparam int INT_BITS = 12;
  localparam int FIX_W = INT_BITS + FRAC_BITS;

  typedef logic signed [FIX_W-1:0] fixT;
  // Same layout without a sign, for track distances that are allowed to wrap
  typedef logic [FIX_W-1:0] ufixT;
  // Full product of two fixT operands
  typedef logic signed [2*FIX_W-1:0] fix2T;

  // Handy fixed-point constants
  localparam fixT FIX_ONE = fixT'(1 << FRAC_BITS);
  localparam fixT FIX_MAX = {1'b0, {(FIX_W-1){1'b1}}};

  // The reciprocal produces one extra quotient bit so that overflow can be seen
  localparam int RCP_QUOT_W = FIX_W + 1;
  localparam int RCP_CNT_W = $clog2(RCP_QUOT_W);

  // 16 by 16 map
  localparam int MAP_COL_BITS = 4;
  localparam int MAP_ROW_BITS = 4;

  typedef struct packed {
    logic [MAP_COL_BITS-1:0] col;
    logic [MAP_ROW_BITS-1:0] row;
  } mapCellT;

  // Player position, facing vector and camera plane, all in map units
  typedef struct packed {
    fixT playerX;
    fixT playerY;
    fixT facingX;
    fixT facingY;
    fixT vplaneX;
    fixT vplaneY;
  } viewT;

  // Ray direction with flags that say which way the grid walk steps
  typedef struct packed {
    fixT dirX;
    fixT dirY;
    logic posX;
    logic posY;
  } rayT;

  // Wall half-size is UQ3.8
  localparam int SIZE_INT = 3;
  localparam int SIZE_FRAC = 8;

  // Side is 0 for an X gridline hit and 1 for a Y gridline hit
  typedef struct packed {
    logic side;
    logic [SIZE_INT+SIZE_FRAC-1:0] size;
  } traceResultT;

  // The sweep starts this many camera-plane steps before the centre ray
  localparam int SWEEP_START_MUL = 272;
  // The deflection accumulates whole vplane steps, so it is scaled back down
  localparam int ADDEND_SHIFT = 8;

  // Wall distance is cut to UQ7.9 before it goes into the size reciprocal
  localparam int VDIST_INT = 7;
  localparam int VDIST_FRAC = 9;

endpackage

`default_nettype wire

// ==== src/raySweep.sv ====
`default_nettype none
`timescale 1ns/100ps

module raySweep import tracerPkg::*; (
  input  wire       clk,
  input  wire       do_reset,
  input  wire viewT i_view,
  input  wire       i_restart,
  input  wire       i_advance,
  output rayT       o_ray
);

  // Deflection from the facing vector, kept at full step resolution
  fixT addendX;
  fixT addendY;
  fixT dirX;
  fixT dirY;

  always_ff @(posedge clk) begin
    if (do_reset) begin
      addendX <= '0;
      addendY <= '0;
    end else if (i_restart) begin
      // Top of the frame sits SWEEP_START_MUL plane steps before the centre
      addendX <= fixT'(-(i_view.vplaneX * SWEEP_START_MUL));
      addendY <= fixT'(-(i_view.vplaneY * SWEEP_START_MUL));
    end else if (i_advance) begin
      // One full camera-plane step per row
      addendX <= addendX + i_view.vplaneX;
      addendY <= addendY + i_view.vplaneY;
    end
  end

  // Ray is the centre direction plus the scaled deflection
  assign dirX = i_view.facingX + (addendX >>> ADDEND_SHIFT);
  assign dirY = i_view.facingY + (addendY >>> ADDEND_SHIFT);

  assign o_ray.dirX = dirX;
  assign o_ray.dirY = dirY;
  // A zero component counts as negative, so the walk steps down on that axis
  assign o_ray.posX = dirX > 0;
  assign o_ray.posY = dirY > 0;

endmodule

`default_nettype wire

// ==== src/reciprocal.sv ====
`default_nettype none
`timescale 1ns/100ps

module reciprocal import tracerPkg::*; (
  input  wire       clk,
  input  wire       do_reset,
  input  wire       i_start,
  input  wire fixT  i_data,
  output logic      o_done,
  output fixT       o_data,
  output logic      o_sat
);

  // Dividend is 1.0 scaled by 2^FRAC_BITS twice, so the quotient lands in Q12.12
  localparam logic [RCP_QUOT_W-1:0] ONE_SQ = RCP_QUOT_W'(1) << (2 * FRAC_BITS);

  ufixT                  absIn;
  ufixT                  divisor;
  logic [RCP_QUOT_W-1:0] rem;
  logic [RCP_QUOT_W-1:0] quot;
  logic [RCP_QUOT_W-1:0] quotNext;
  logic [RCP_QUOT_W:0]   loadStep;
  logic [RCP_QUOT_W:0]   runStep;
  logic [RCP_CNT_W-1:0]  stepsLeft;
  logic                  busy;
  logic                  overflow;

  // One restoring step returns the new remainder above the quotient bit
  function automatic logic [RCP_QUOT_W:0] divStep(input logic [RCP_QUOT_W-1:0] remIn,
                                                  input ufixT                  dvsr,
                                                  input logic                  dvdBit);
    logic [RCP_QUOT_W-1:0] trial;
    trial = {remIn[RCP_QUOT_W-2:0], dvdBit};
    if (trial >= {1'b0, dvsr}) begin
      divStep = {trial - {1'b0, dvsr}, 1'b1};
    end else begin
      divStep = {trial, 1'b0};
    end
  endfunction

  // The sign is dropped, callers only need the magnitude of the step
  assign absIn = i_data[FIX_W-1] ? ufixT'(-i_data) : ufixT'(i_data);

  // Top dividend bit is consumed in the load cycle itself
  assign loadStep = divStep('0, absIn, ONE_SQ[RCP_QUOT_W-1]);
  // Every dividend bit below the top one is zero
  assign runStep = divStep(rem, divisor, 1'b0);
  assign quotNext = {quot[RCP_QUOT_W-2:0], runStep[0]};

  // Quotient of 2^23 or more does not fit, this also catches a zero input
  assign overflow = |quotNext[RCP_QUOT_W-1:FIX_W-1];

  always_ff @(posedge clk) begin
    if (do_reset) begin
      busy <= 1'b0;
      stepsLeft <= '0;
      o_done <= 1'b0;
      o_sat <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (busy) begin
        stepsLeft <= stepsLeft - 1'b1;
        // Last quotient bit goes in now and the result is shown next cycle
        if (stepsLeft == RCP_CNT_W'(1)) begin
          busy <= 1'b0;
          o_done <= 1'b1;
          o_sat <= overflow;
        end
      end else if (i_start) begin
        busy <= 1'b1;
        stepsLeft <= RCP_CNT_W'(FIX_W);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (busy) begin
      rem <= runStep[RCP_QUOT_W:1];
      quot <= quotNext;
      if (stepsLeft == RCP_CNT_W'(1)) begin
        o_data <= overflow ? FIX_MAX : fixT'(quotNext[FIX_W-1:0]);
      end
    end else if (i_start) begin
      divisor <= absIn;
      rem <= loadStep[RCP_QUOT_W:1];
      quot <= {{(RCP_QUOT_W-1){1'b0}}, loadStep[0]};
    end
  end

endmodule

`default_nettype wire

// ==== src/gridWalker.sv ====
`default_nettype none
`timescale 1ns/100ps

module gridWalker import tracerPkg::*; (
  input  wire          clk,
  input  wire          do_reset,
  input  wire          i_start,
  input  wire viewT    i_view,
  input  wire rayT     i_ray,
  input  wire fixT     i_stepX,
  input  wire fixT     i_stepY,
  input  wire          i_mapVal,
  output mapCellT      o_mapCell,
  output logic         o_hit,
  output logic         o_side,
  output ufixT         o_vdist
);

  // Idle also holds the hit cell and distance after a walk
  typedef enum logic [1:0] {
    Idle,
    SeedX,
    SeedY,
    Walk
  } phaseT;

  phaseT                phase;
  logic [FRAC_BITS-1:0] fracX;
  logic [FRAC_BITS-1:0] fracY;
  fixT                  partialX;
  fixT                  partialY;
  fixT                  mulA;
  fixT                  mulB;
  fix2T                 product;
  ufixT                 seed;
  ufixT                 trackX;
  ufixT                 trackY;
  logic                 stepAlongX;

  // Where the player sits inside its own cell
  assign fracX = i_view.playerX[FRAC_BITS-1:0];
  assign fracY = i_view.playerY[FRAC_BITS-1:0];

  // Distance to the first gridline, measured in the direction of travel
  assign partialX = i_ray.posX ? FIX_ONE - fixT'(fracX) : fixT'(fracX);
  assign partialY = i_ray.posY ? FIX_ONE - fixT'(fracY) : fixT'(fracY);

  // One multiplier seeds X in the first cycle and Y in the second
  assign mulA = (phase == SeedY) ? i_stepY : i_stepX;
  assign mulB = (phase == SeedY) ? partialY : partialX;
  assign product = mulA * mulB;
  // Middle of the product is back in Q12.12
  assign seed = ufixT'(product[FRAC_BITS +: FIX_W]);

  // Unsigned compare, so a wrapped track never looks nearer. Ties go to Y
  assign stepAlongX = trackX < trackY;

  // The cell under test is a wall, so the walk stops here
  assign o_hit = (phase == Walk) && i_mapVal;

  always_ff @(posedge clk) begin
    if (do_reset) begin
      phase <= Idle;
      o_mapCell <= '0;
      o_side <= 1'b0;
    end else if (i_start) begin
      phase <= SeedX;
      // Walk begins in the cell the player stands in
      o_mapCell.col <= i_view.playerX[FRAC_BITS +: MAP_COL_BITS];
      o_mapCell.row <= i_view.playerY[FRAC_BITS +: MAP_ROW_BITS];
    end else begin
      case (phase)
        SeedX: phase <= SeedY;
        SeedY: phase <= Walk;
        Walk: begin
          if (i_mapVal) begin
            phase <= Idle;
          end else if (stepAlongX) begin
            o_mapCell.col <= i_ray.posX ? o_mapCell.col + 1'b1 : o_mapCell.col - 1'b1;
            o_side <= 1'b0;
          end else begin
            o_mapCell.row <= i_ray.posY ? o_mapCell.row + 1'b1 : o_mapCell.row - 1'b1;
            o_side <= 1'b1;
          end
        end
        default: phase <= Idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (phase)
      SeedX: trackX <= seed;
      SeedY: trackY <= seed;
      Walk: begin
        // Track distance before the step is the perpendicular wall distance
        if (!i_mapVal) begin
          if (stepAlongX) begin
            trackX <= trackX + ufixT'(i_stepX);
            o_vdist <= trackX;
          end else begin
            trackY <= trackY + ufixT'(i_stepY);
            o_vdist <= trackY;
          end
        end
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/traceSequencer.sv ====
`default_nettype none
`timescale 1ns/100ps

module traceSequencer import tracerPkg::*; (
  input  wire         clk,
  input  wire         do_reset,
  input  wire         i_vsync,
  input  wire         i_hmax,
  input  wire rayT    i_ray,
  input  wire ufixT   i_vdist,
  input  wire         i_hitSide,
  input  wire         i_hit,
  output logic        o_rcpStart,
  output fixT         o_rcpData,
  input  wire         i_rcpDone,
  input  wire fixT    i_rcpData,
  output logic        o_restart,
  output logic        o_advance,
  output logic        o_walkStart,
  output fixT         o_stepX,
  output fixT         o_stepY,
  output traceResultT o_result
);

  localparam int VDIST_W = VDIST_INT + VDIST_FRAC;

  typedef enum logic [2:0] {
    StepX,
    StepY,
    Walk,
    Size,
    Done
  } stateT;

  stateT              state;
  logic               rcpBusy;
  logic               issued;
  logic               needRcp;
  logic               rcpAccept;
  logic [VDIST_W-1:0] vdistTrunc;

  // UQ7.9 slice of the wall distance
  assign vdistTrunc = i_vdist[FRAC_BITS+VDIST_INT-1 -: VDIST_W];

  // Three states each need one reciprocal result
  assign needRcp = (state == StepX) || (state == StepY) || (state == Size);

  // A divide left over from before a vsync must drain before a new one starts
  assign o_rcpStart = needRcp && !issued && !rcpBusy && !i_vsync;

  // Only a result that this state asked for moves it on
  assign rcpAccept = issued && i_rcpDone;

  always_comb begin
    case (state)
      StepX: o_rcpData = i_ray.dirX;
      StepY: o_rcpData = i_ray.dirY;
      default: o_rcpData = fixT'({vdistTrunc, {(FRAC_BITS-VDIST_FRAC){1'b0}}});
    endcase
  end

  // Sweep stays parked at the top row for as long as vsync is high
  assign o_restart = i_vsync;
  // Next ray is needed right after the result is handed over
  assign o_advance = (state == Done) && i_hmax && !i_vsync;

  always_ff @(posedge clk) begin
    if (do_reset) begin
      state <= StepX;
      rcpBusy <= 1'b0;
      issued <= 1'b0;
      o_walkStart <= 1'b0;
      o_result <= '0;
    end else begin
      o_walkStart <= 1'b0;

      // Mirror of the divider busy flag, kept through vsync
      if (o_rcpStart) begin
        rcpBusy <= 1'b1;
      end else if (i_rcpDone) begin
        rcpBusy <= 1'b0;
      end

      if (i_vsync) begin
        state <= StepX;
        issued <= 1'b0;
      end else begin
        if (o_rcpStart) begin
          issued <= 1'b1;
        end
        case (state)
          StepX: begin
            if (rcpAccept) begin
              issued <= 1'b0;
              state <= StepY;
            end
          end
          StepY: begin
            // Both step distances are latched, so the walk can begin
            if (rcpAccept) begin
              issued <= 1'b0;
              o_walkStart <= 1'b1;
              state <= Walk;
            end
          end
          Walk: begin
            if (i_hit) begin
              state <= Size;
            end
          end
          Size: begin
            if (rcpAccept) begin
              issued <= 1'b0;
              state <= Done;
            end
          end
          default: begin
            // Size reciprocal holds its value until the next start
            if (i_hmax) begin
              o_result.side <= i_hitSide;
              o_result.size <= i_rcpData[FRAC_BITS+SIZE_INT-1 -: SIZE_INT+SIZE_FRAC];
              state <= StepX;
            end
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rcpAccept && (state == StepX)) begin
      o_stepX <= i_rcpData;
    end
    if (rcpAccept && (state == StepY)) begin
      o_stepY <= i_rcpData;
    end
  end

endmodule

`default_nettype wire

// ==== src/wallTracer.sv ====
`default_nettype none
`timescale 1ns/100ps

module wallTracer import tracerPkg::*; (
  input  wire         clk,
  input  wire         do_reset,
  input  wire         i_vsync,
  input  wire         i_hmax,
  input  wire viewT   i_view,
  output mapCellT     o_mapCell,
  input  wire         i_mapVal,
  output traceResultT o_result
);

  rayT  ray;
  logic restart;
  logic advance;
  logic rcpStart;
  logic rcpDone;
  fixT  rcpIn;
  fixT  rcpOut;
  logic walkStart;
  fixT  stepX;
  fixT  stepY;
  ufixT vdist;
  logic hitSide;
  logic hit;

  // Current row's ray, straight from the deflection accumulator
  raySweep sweep (
    .clk       (clk),
    .do_reset  (do_reset),
    .i_view    (i_view),
    .i_restart (restart),
    .i_advance (advance),
    .o_ray     (ray)
  );

  // One divider serves both step distances and the wall size
  reciprocal rcp (
    .clk      (clk),
    .do_reset (do_reset),
    .i_start  (rcpStart),
    .i_data   (rcpIn),
    .o_done   (rcpDone),
    .o_data   (rcpOut),
    .o_sat    ()
  );

  gridWalker walker (
    .clk       (clk),
    .do_reset  (do_reset),
    .i_start   (walkStart),
    .i_view    (i_view),
    .i_ray     (ray),
    .i_stepX   (stepX),
    .i_stepY   (stepY),
    .i_mapVal  (i_mapVal),
    .o_mapCell (o_mapCell),
    .o_hit     (hit),
    .o_side    (hitSide),
    .o_vdist   (vdist)
  );

  traceSequencer seq (
    .clk         (clk),
    .do_reset    (do_reset),
    .i_vsync     (i_vsync),
    .i_hmax      (i_hmax),
    .i_ray       (ray),
    .i_vdist     (vdist),
    .i_hitSide   (hitSide),
    .i_hit       (hit),
    .o_rcpStart  (rcpStart),
    .o_rcpData   (rcpIn),
    .i_rcpDone   (rcpDone),
    .i_rcpData   (rcpOut),
    .o_restart   (restart),
    .o_advance   (advance),
    .o_walkStart (walkStart),
    .o_stepX     (stepX),
    .o_stepY     (stepY),
    .o_result    (o_result)
  );

endmodule

`default_nettype wire

// ==== tb/tbClock.sv ====
`default_nettype none
`timescale 1ns/100ps

module tbClock (
  output logic clk,
  output logic do_reset
);

  // 10 ns period
  localparam int HALF_PERIOD = 5;
  localparam int RESET_CYCLES = 8;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Reset is released on a falling edge so the DUT sees a clean level at the next rising edge
  initial begin
    do_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    do_reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb/wallTracerTb.sv ====
`default_nettype none
`timescale 1ns/100ps

module wallTracerTb import tracerPkg::*; ();

  localparam int NUM_ROWS = 12;
  // Rows played before the mid-frame vsync
  localparam int FIRST_PASS_ROWS = 6;
  localparam int HMAX_PERIOD = 200;
  localparam int EXTRA_HMAX_DELAY = 10;
  // Rows 5 and 6 hit different cells, so a wrongly accepted pulse shows up in row 5
  localparam int EXTRA_AFTER_ROW = 4;
  localparam int VSYNC_CYCLES = 20;
  localparam int MAP_WORDS = 16;
  localparam int VIEW_WORDS = 6;
  localparam int CASE_WORDS = MAP_WORDS + VIEW_WORDS + 2 * NUM_ROWS;
  // Every played row costs one hmax period and the rest covers reset and both vsync phases
  localparam int CYCLE_LIMIT = (FIRST_PASS_ROWS + NUM_ROWS) * HMAX_PERIOD + 400;

  logic        clk;
  logic        do_reset;
  logic        vsync;
  logic        hmax;
  viewT        view;
  mapCellT     mapCell;
  logic        mapVal;
  traceResultT result;

  logic [23:0] caseWords [0:CASE_WORDS-1];
  logic [15:0] mapRows [0:15];
  mapCellT     expCell [0:NUM_ROWS-1];
  traceResultT expResult [0:NUM_ROWS-1];
  int          errors;
  int          cycles = 0;

  tbClock clockGen (
    .clk      (clk),
    .do_reset (do_reset)
  );

  wallTracer DUT (
    .clk       (clk),
    .do_reset  (do_reset),
    .i_vsync   (vsync),
    .i_hmax    (hmax),
    .i_view    (view),
    .o_mapCell (mapCell),
    .i_mapVal  (mapVal),
    .o_result  (result)
  );

  // The map answers in the same cycle and bit n of a row word is column n
  assign mapVal = mapRows[mapCell.row][mapCell.col];

  task automatic checkResult(input string name, input traceResultT got, input traceResultT exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkCell(input string name, input mapCellT got, input mapCellT exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch %s got %h expected %h", name, got, exp);
    end
  endtask

  // Result register must still hold its reset value
  task automatic checkIdle(input traceResultT got);
    if (got !== '0) begin
      errors++;
      $display("mismatch o_result got %h expected %h", got, traceResultT'(0));
    end
  endtask

  task automatic loadCases();
    int i;
    $readmemh("tb/wallTracerCases.txt", caseWords);
    if ($isunknown(caseWords[CASE_WORDS-1])) begin
      errors++;
      $display("cases file is missing or holds fewer words than expected");
    end
    for (i = 0; i < MAP_WORDS; i++) begin
      mapRows[i] = caseWords[i][15:0];
    end
    view.playerX = fixT'(caseWords[MAP_WORDS]);
    view.playerY = fixT'(caseWords[MAP_WORDS + 1]);
    view.facingX = fixT'(caseWords[MAP_WORDS + 2]);
    view.facingY = fixT'(caseWords[MAP_WORDS + 3]);
    view.vplaneX = fixT'(caseWords[MAP_WORDS + 4]);
    view.vplaneY = fixT'(caseWords[MAP_WORDS + 5]);
    for (i = 0; i < NUM_ROWS; i++) begin
      expCell[i] = mapCellT'(caseWords[MAP_WORDS + VIEW_WORDS + 2 * i][7:0]);
      expResult[i] = traceResultT'(caseWords[MAP_WORDS + VIEW_WORDS + 2 * i + 1][11:0]);
    end
    // A hit cell that is open in the map would point at a broken case line
    for (i = 0; i < NUM_ROWS; i++) begin
      if (mapRows[expCell[i].row][expCell[i].col] !== 1'b1) begin
        errors++;
        $display("expected hit cell of row %0d is not a wall in the map", i);
      end
    end
  endtask

  // Each row takes one hmax period and its trace is long finished by the end of it
  task automatic playRow(input int row);
    repeat (HMAX_PERIOD - 1) @(negedge clk);
    checkCell("o_mapCell", mapCell, expCell[row]);
    hmax = 1'b1;
    @(negedge clk);
    hmax = 1'b0;
    checkResult("o_result", result, expResult[row]);
  endtask

  // The next row is still being traced, so this pulse must be dropped without a sweep step
  task automatic sendEarlyHmax(input int row);
    repeat (EXTRA_HMAX_DELAY - 1) @(negedge clk);
    hmax = 1'b1;
    @(negedge clk);
    hmax = 1'b0;
    checkResult("o_result", result, expResult[row]);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("run stopped after %0d cycles before all rows were played", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    int row;
    errors = 0;
    vsync = 1'b1;
    hmax = 1'b0;
    view = '0;
    loadCases();

    while (do_reset !== 1'b0) begin
      @(negedge clk);
    end

    // Tracer is parked at the top row while vsync is high
    repeat (VSYNC_CYCLES) begin
      @(negedge clk);
      checkIdle(result);
    end
    vsync = 1'b0;

    for (row = 0; row < FIRST_PASS_ROWS; row++) begin
      playRow(row);
      if (row == EXTRA_AFTER_ROW) begin
        sendEarlyHmax(row);
      end
    end

    // Vsync in mid frame sends the sweep back to row 0
    vsync = 1'b1;
    repeat (VSYNC_CYCLES) @(negedge clk);
    vsync = 1'b0;

    for (row = 0; row < NUM_ROWS; row++) begin
      playRow(row);
    end

    $display("checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/wallTracerCases.txt ====
// Words in order: 16 map rows where bit n set means column n is a wall, then the view as
// playerX playerY facingX facingY vplaneX vplaneY, then per row the hit cell {col,row} and {side,size}
FFFF   // Map row 0 is the top border
8001   // Map row 1 is open between the borders
9001   // Map row 2 has a wall at column 12
8201   // Map row 3 has a wall at column 9
8401   // Map row 4 has a wall at column 10
8001
8001
8001
8001
8001
8001
8001
8001
8001
8001
FFFF   // Map row 15 is the bottom border
001000 001800   // Player stands at x 1.0 and y 1.5
001000 007F80   // Facing vector
000000 007800   // Camera plane
F1 012   // Ray 0 never steps in y
F1 012   // Ray 1
C2 017   // Ray 2
C2 017   // Ray 3
C2 017   // Ray 4
F3 012   // Ray 5 passes column 12 one row higher
93 81E   // Ray 6 enters the wall cell from below
93 020   // Ray 7
93 020   // Ray 8
93 020   // Ray 9
93 020   // Ray 10
A4 01C   // Ray 11

// ==== flist.f ====
src/tracerPkg.sv
src/raySweep.sv
src/reciprocal.sv
src/gridWalker.sv
src/traceSequencer.sv
src/wallTracer.sv
tb/tbClock.sv
tb/wallTracerTb.sv
